// File: hdl/sdc_pkg.sv
// Shared constants and types for the SD host control block; only HADDR[7:0] is decoded
package sdc_pkg;

  //////////////////////////////
  // Bus and decode widths
  //////////////////////////////
  localparam int BUS_W = 32;
  localparam int OFS_W = 8;

  // Register offsets within the decoded window
  localparam logic [OFS_W-1:0] OFS_ARGUMENT     = 8'h00;
  localparam logic [OFS_W-1:0] OFS_COMMAND      = 8'h04;
  localparam logic [OFS_W-1:0] OFS_CONTROLLER   = 8'h1C;
  localparam logic [OFS_W-1:0] OFS_BLKSIZE      = 8'h20;
  localparam logic [OFS_W-1:0] OFS_VOLTAGE      = 8'h24;
  localparam logic [OFS_W-1:0] OFS_CAPA         = 8'h28;
  localparam logic [OFS_W-1:0] OFS_CLOCK_D      = 8'h2C;
  localparam logic [OFS_W-1:0] OFS_RESET        = 8'h30;
  localparam logic [OFS_W-1:0] OFS_CMD_TIMEOUT  = 8'h34;
  localparam logic [OFS_W-1:0] OFS_DATA_TIMEOUT = 8'h38;
  localparam logic [OFS_W-1:0] OFS_BLKCNT       = 8'h48;
  localparam logic [OFS_W-1:0] OFS_CARD_DETECT  = 8'h4C;
  localparam logic [OFS_W-1:0] OFS_DMA_ADDR     = 8'h60;

  // Stored field widths
  localparam int CMD_REG_W      = 14;
  localparam int CMD_TIMEOUT_W  = 25;
  localparam int DATA_TIMEOUT_W = 24;
  localparam int BLKSIZE_W      = 12;
  localparam int BLKCNT_W       = 16;
  localparam int CTRL_W         = 2;
  localparam int CLKDIV_W       = 8;

  //////////////////////////////
  // Reset and constant values
  //////////////////////////////
  localparam logic [BLKSIZE_W-1:0] RESET_BLOCK_SIZE = 12'd511;
  // Divider for roughly 400 kHz identification clock
  localparam logic [CLKDIV_W-1:0]  RESET_CLOCK_DIV  = 8'd124;
  // Card supply in millivolts
  localparam logic [BUS_W-1:0]     VOLTAGE_VALUE    = 32'd3300;
  // Low bits are capability flags and the DMA address width sits from bit 8 up
  localparam logic [BUS_W-1:0]     CAPA_VALUE       = 32'd3 | (32'd32 << 8);

  // Card detect pin level for a present card
  localparam logic CD_DETECT_LEVEL = 1'b1;
  localparam int   CD_DEBOUNCE_W   = 26;

  // One bus request as seen by the register file and the read mux
  typedef struct packed {
    logic             wr_commit;
    logic             rd;
    logic [OFS_W-1:0] rd_ofs;
    logic [OFS_W-1:0] wr_ofs;
    logic [BUS_W-1:0] wdata;
  } ahb_req_t;

  // Reset register bits in readback order
  typedef struct packed {
    logic cmd_start;
    logic data_int_rst;
    logic cmd_int_rst;
    logic ctrl_rst;
  } rst_bits_t;

  // Flag view of the card detect word
  typedef struct packed {
    logic [BUS_W-5:0] rsvd;
    logic             remove_int;
    logic             remove_ie;
    logic             insert_int;
    logic             insert_ie;
  } cd_flags_t;

  // Card detect word as raw bus data or as flags
  typedef union packed {
    logic [BUS_W-1:0] raw;
    cd_flags_t        flags;
  } cd_word_u;

  // Everything the read mux can return
  typedef struct packed {
    logic [BUS_W-1:0]          argument;
    logic [CMD_REG_W-1:0]      command;
    logic [CTRL_W-1:0]         controller;
    logic [BLKSIZE_W-1:0]      blksize;
    logic [CLKDIV_W-1:0]       clock_div;
    logic [CMD_TIMEOUT_W-1:0]  cmd_timeout;
    logic [DATA_TIMEOUT_W-1:0] data_timeout;
    logic [BLKCNT_W-1:0]       blkcnt;
    logic [BUS_W-1:0]          dma_addr;
    rst_bits_t                 rst_bits;
    cd_word_u                  card_detect;
  } reg_view_t;

endpackage

// File: hdl/sdc_ahb_slave.sv
// Single transfers only with zero wait states; no HSIZE or HWSTRB, every write is a full word
`timescale 1ns/1ps

module sdc_ahb_slave (
  input  logic                          HCLK,
  input  logic                          reset,
  input  logic                          hsel_i,
  input  logic                          hready_i,
  input  logic [1:0]                    htrans_i,
  input  logic                          hwrite_i,
  input  logic [sdc_pkg::OFS_W-1:0]     haddr_i,
  input  logic [sdc_pkg::BUS_W-1:0]     hwdata_i,
  output sdc_pkg::ahb_req_t             req_o
);

  //////////////////////////////
  // Address phase decode
  //////////////////////////////
  logic                      xfer_start;
  logic                      wr_start;
  logic                      wr_pend;
  logic [sdc_pkg::OFS_W-1:0] wr_ofs;

  // NONSEQ or SEQ on a selected, ready bus
  assign xfer_start = hready_i & hsel_i & htrans_i[1];
  assign wr_start   = xfer_start & hwrite_i;

  // Write is pending into its data phase
  always_ff @(posedge HCLK) begin
    if (reset) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= wr_start;
    end
  end

  // Offset held for the data phase
  always_ff @(posedge HCLK) begin
    if (wr_start) begin
      wr_ofs <= haddr_i;
    end
  end

  //////////////////////////////
  // Request to the register side
  //////////////////////////////
  always_comb begin
    req_o.wr_commit = wr_pend;
    req_o.wr_ofs    = wr_ofs;
    // Data phase data goes with the commit
    req_o.wdata     = hwdata_i;
    // Reads are served from the address phase
    req_o.rd        = xfer_start & ~hwrite_i;
    req_o.rd_ofs    = haddr_i;
  end

endmodule

// File: hdl/sdc_clock_gen.sv
// SD clock is HCLK divided by 2*(div+1); no stalls for FIFO level, div changes take effect at once
`timescale 1ns/1ps

module sdc_clock_gen (
  input  logic                          HCLK,
  input  logic                          reset,
  input  logic [sdc_pkg::CLKDIV_W-1:0]  clock_div_i,
  input  logic                          sdio_reset_i,
  output logic                          clock_posedge_o,
  output logic                          sdio_clk_o
);

  //////////////////////////////
  // Divider and clock state
  //////////////////////////////
  logic [sdc_pkg::CLKDIV_W-1:0] clock_cnt;
  logic                         clock_state;

  always_ff @(posedge HCLK) begin
    if (reset) begin
      clock_cnt       <= '0;
      clock_state     <= 1'b0;
      clock_posedge_o <= 1'b0;
    end else if (clock_cnt < clock_div_i) begin
      // Still counting this half period
      clock_cnt       <= clock_cnt + 1'b1;
      clock_posedge_o <= 1'b0;
    end else begin
      // Half period done so flip state
      clock_cnt       <= '0;
      clock_state     <= ~clock_state;
      // Pulse only on a low to high flip
      clock_posedge_o <= ~clock_state;
    end
  end

  //////////////////////////////
  // Card clock output
  //////////////////////////////
  // One cycle behind the state and parked high while the card is held in reset
  always_ff @(posedge HCLK) begin
    if (reset) begin
      sdio_clk_o <= 1'b0;
    end else begin
      sdio_clk_o <= sdio_reset_i | clock_state;
    end
  end

  // Rising edge strobe is always a single cycle
  a_posedge_single : assert property (
    @(posedge HCLK) disable iff (reset)
    clock_posedge_o |=> !clock_posedge_o
  );

endmodule

// File: hdl/sdc_card_detect.sv
// No reset input; the pin must leave the detect level once before insert_int is valid
`timescale 1ns/1ps

module sdc_card_detect #(
  parameter int DEBOUNCE_W = sdc_pkg::CD_DEBOUNCE_W
) (
  input  logic HCLK,
  input  logic sdio_cd_i,
  output logic insert_int_o
);

  //////////////////////////////
  // Debounce counter
  //////////////////////////////
  logic [DEBOUNCE_W-1:0] detect_cnt;

  // Any glitch off the detect level restarts the count
  always_ff @(posedge HCLK) begin
    if (sdio_cd_i != sdc_pkg::CD_DETECT_LEVEL) begin
      detect_cnt <= '0;
    end else if (!detect_cnt[DEBOUNCE_W-1]) begin
      // Count until the top bit saturates
      detect_cnt <= detect_cnt + 1'b1;
    end
  end

  // Top bit set means card held in long enough
  assign insert_int_o = detect_cnt[DEBOUNCE_W-1];

  // Saturation keeps the count off zero while the card stays in
  a_no_wrap : assert property (
    @(posedge HCLK)
    (sdio_cd_i == sdc_pkg::CD_DETECT_LEVEL && !$isunknown(detect_cnt))
      |=> (detect_cnt != '0)
  );

endmodule

// File: hdl/sdc_regs.sv
// Timeouts, block size, block count and DMA address are storage only; only card interrupts exist
`timescale 1ns/1ps

module sdc_regs (
  input  logic                          HCLK,
  input  logic                          reset,
  input  sdc_pkg::ahb_req_t             req_i,
  input  logic                          clock_posedge_i,
  input  logic                          insert_int_i,
  output sdc_pkg::reg_view_t            view_o,
  output logic [sdc_pkg::CLKDIV_W-1:0]  clock_div_o,
  output logic                          sdio_reset_o,
  output logic                          interrupt_o
);

  //////////////////////////////
  // Register storage
  //////////////////////////////
  logic [sdc_pkg::BUS_W-1:0]          argument_reg;
  logic [sdc_pkg::CMD_REG_W-1:0]      command_reg;
  logic [sdc_pkg::CTRL_W-1:0]         controller_reg;
  logic [sdc_pkg::BLKSIZE_W-1:0]      blksize_reg;
  logic [sdc_pkg::CLKDIV_W-1:0]       clock_div_reg;
  logic                               sw_reset_reg;
  logic [sdc_pkg::CMD_TIMEOUT_W-1:0]  cmd_timeout_reg;
  logic [sdc_pkg::DATA_TIMEOUT_W-1:0] data_timeout_reg;
  logic [sdc_pkg::BLKCNT_W-1:0]       blkcnt_reg;
  logic [sdc_pkg::BUS_W-1:0]          dma_addr_reg;
  logic                               insert_ie;
  logic                               remove_ie;
  logic                               cmd_start;
  logic                               ctrl_rst;
  sdc_pkg::cd_word_u                  cd_wr;
  sdc_pkg::cd_word_u                  cd_rd;

  // Incoming bus word seen as card detect flags
  assign cd_wr.raw = req_i.wdata;

  always_ff @(posedge HCLK) begin
    if (reset) begin
      argument_reg     <= '0;
      command_reg      <= '0;
      controller_reg   <= '0;
      blksize_reg      <= sdc_pkg::RESET_BLOCK_SIZE;
      clock_div_reg    <= sdc_pkg::RESET_CLOCK_DIV;
      sw_reset_reg     <= 1'b0;
      cmd_timeout_reg  <= '0;
      data_timeout_reg <= '0;
      blkcnt_reg       <= '0;
      dma_addr_reg     <= '0;
      insert_ie        <= 1'b0;
      remove_ie        <= 1'b0;
      cmd_start        <= 1'b0;
      ctrl_rst         <= 1'b0;
      sdio_reset_o     <= 1'b0;
    end else begin
      // Slow side samples once per SD clock rise
      if (clock_posedge_i) begin
        cmd_start    <= 1'b0;
        ctrl_rst     <= sw_reset_reg;
        sdio_reset_o <= controller_reg[1];
      end
      // Commit decode keeps the low bits of each field
      if (req_i.wr_commit) begin
        case (req_i.wr_ofs)
          sdc_pkg::OFS_ARGUMENT: begin
            argument_reg <= req_i.wdata;
            // Argument write kicks off a command and wins over the clear
            cmd_start    <= 1'b1;
          end
          sdc_pkg::OFS_COMMAND:
            command_reg <= req_i.wdata[sdc_pkg::CMD_REG_W-1:0];
          sdc_pkg::OFS_CONTROLLER:
            controller_reg <= req_i.wdata[sdc_pkg::CTRL_W-1:0];
          sdc_pkg::OFS_BLKSIZE:
            blksize_reg <= req_i.wdata[sdc_pkg::BLKSIZE_W-1:0];
          sdc_pkg::OFS_CLOCK_D:
            clock_div_reg <= req_i.wdata[sdc_pkg::CLKDIV_W-1:0];
          sdc_pkg::OFS_RESET:
            sw_reset_reg <= req_i.wdata[0];
          sdc_pkg::OFS_CMD_TIMEOUT:
            cmd_timeout_reg <= req_i.wdata[sdc_pkg::CMD_TIMEOUT_W-1:0];
          sdc_pkg::OFS_DATA_TIMEOUT:
            data_timeout_reg <= req_i.wdata[sdc_pkg::DATA_TIMEOUT_W-1:0];
          sdc_pkg::OFS_BLKCNT:
            blkcnt_reg <= req_i.wdata[sdc_pkg::BLKCNT_W-1:0];
          sdc_pkg::OFS_CARD_DETECT: begin
            // Only the enables are writable
            remove_ie <= cd_wr.flags.remove_ie;
            insert_ie <= cd_wr.flags.insert_ie;
          end
          sdc_pkg::OFS_DMA_ADDR:
            dma_addr_reg <= req_i.wdata;
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // Card detect word and interrupt
  //////////////////////////////
  always_comb begin
    cd_rd.raw              = '0;
    cd_rd.flags.remove_int = ~insert_int_i;
    cd_rd.flags.remove_ie  = remove_ie;
    cd_rd.flags.insert_int = insert_int_i;
    cd_rd.flags.insert_ie  = insert_ie;
  end

  assign interrupt_o = (cd_rd.flags.insert_int & cd_rd.flags.insert_ie)
                     | (cd_rd.flags.remove_int & cd_rd.flags.remove_ie);

  assign clock_div_o = clock_div_reg;

  //////////////////////////////
  // Readback view
  //////////////////////////////
  always_comb begin
    view_o.argument              = argument_reg;
    view_o.command               = command_reg;
    view_o.controller            = controller_reg;
    view_o.blksize               = blksize_reg;
    view_o.clock_div             = clock_div_reg;
    view_o.cmd_timeout           = cmd_timeout_reg;
    view_o.data_timeout          = data_timeout_reg;
    view_o.blkcnt                = blkcnt_reg;
    view_o.dma_addr              = dma_addr_reg;
    view_o.rst_bits.cmd_start    = cmd_start;
    // No command or data engine behind these
    view_o.rst_bits.data_int_rst = 1'b0;
    view_o.rst_bits.cmd_int_rst  = 1'b0;
    view_o.rst_bits.ctrl_rst     = ctrl_rst;
    view_o.card_detect           = cd_rd;
  end

  // Command start is only retired by the SD clock rise
  a_cmd_start_fall : assert property (
    @(posedge HCLK) disable iff (reset)
    $fell(cmd_start) |-> $past(clock_posedge_i)
  );

endmodule

// File: hdl/sdc_read_mux.sv
// Read word is registered one cycle; unmapped offsets and idle cycles return zero
`timescale 1ns/1ps

module sdc_read_mux (
  input  logic                          HCLK,
  input  logic                          reset,
  input  sdc_pkg::ahb_req_t             req_i,
  input  sdc_pkg::reg_view_t            view_i,
  output logic [sdc_pkg::BUS_W-1:0]     hrdata_o
);

  //////////////////////////////
  // Offset select
  //////////////////////////////
  logic [sdc_pkg::BUS_W-1:0] rd_word;

  // Narrow fields land in the low bits and the rest stays zero
  always_comb begin
    rd_word = '0;
    case (req_i.rd_ofs)
      sdc_pkg::OFS_ARGUMENT:     rd_word = view_i.argument;
      sdc_pkg::OFS_COMMAND:      rd_word[sdc_pkg::CMD_REG_W-1:0] = view_i.command;
      sdc_pkg::OFS_CONTROLLER:   rd_word[sdc_pkg::CTRL_W-1:0] = view_i.controller;
      sdc_pkg::OFS_BLKSIZE:      rd_word[sdc_pkg::BLKSIZE_W-1:0] = view_i.blksize;
      sdc_pkg::OFS_VOLTAGE:      rd_word = sdc_pkg::VOLTAGE_VALUE;
      sdc_pkg::OFS_CAPA:         rd_word = sdc_pkg::CAPA_VALUE;
      sdc_pkg::OFS_CLOCK_D:      rd_word[sdc_pkg::CLKDIV_W-1:0] = view_i.clock_div;
      // Four strobe bits with cmd_start on top
      sdc_pkg::OFS_RESET:        rd_word[3:0] = view_i.rst_bits;
      sdc_pkg::OFS_CMD_TIMEOUT:
        rd_word[sdc_pkg::CMD_TIMEOUT_W-1:0] = view_i.cmd_timeout;
      sdc_pkg::OFS_DATA_TIMEOUT:
        rd_word[sdc_pkg::DATA_TIMEOUT_W-1:0] = view_i.data_timeout;
      sdc_pkg::OFS_BLKCNT:       rd_word[sdc_pkg::BLKCNT_W-1:0] = view_i.blkcnt;
      sdc_pkg::OFS_CARD_DETECT:  rd_word = view_i.card_detect.raw;
      sdc_pkg::OFS_DMA_ADDR:     rd_word = view_i.dma_addr;
      default:                   rd_word = '0;
    endcase
  end

  //////////////////////////////
  // Data phase register
  //////////////////////////////
  // Captured at the end of the address phase
  always_ff @(posedge HCLK) begin
    if (reset) begin
      hrdata_o <= '0;
    end else if (req_i.rd) begin
      hrdata_o <= rd_word;
    end else begin
      // Bus idles at zero outside read data phases
      hrdata_o <= '0;
    end
  end

endmodule

// File: hdl/sdc_top.sv
// Control side only; command and data engines, FIFO and DMA master are not present
`timescale 1ns/1ps

module sdc_top #(
  parameter int CD_DEBOUNCE_W = sdc_pkg::CD_DEBOUNCE_W
) (
  input  logic                          HCLK,
  input  logic                          reset,
  input  logic                          hsel_i,
  input  logic                          hready_i,
  input  logic [1:0]                    htrans_i,
  input  logic                          hwrite_i,
  input  logic [sdc_pkg::OFS_W-1:0]     haddr_i,
  input  logic [sdc_pkg::BUS_W-1:0]     hwdata_i,
  output logic [sdc_pkg::BUS_W-1:0]     hrdata_o,
  output logic                          hreadyout_o,
  output logic                          hresp_o,
  input  logic                          sdio_cd_i,
  output logic                          sdio_clk_o,
  output logic                          sdio_reset_o,
  output logic                          interrupt_o
);

  sdc_pkg::ahb_req_t            req;
  sdc_pkg::reg_view_t           view;
  logic                         clock_posedge;
  logic [sdc_pkg::CLKDIV_W-1:0] clock_div;
  logic                         insert_int;

  //////////////////////////////
  // Bus side
  //////////////////////////////
  // Zero wait states and always OKAY
  assign hreadyout_o = 1'b1;
  assign hresp_o     = 1'b0;

  sdc_ahb_slave i_ahb_slave (
    .HCLK     (HCLK),
    .reset    (reset),
    .hsel_i   (hsel_i),
    .hready_i (hready_i),
    .htrans_i (htrans_i),
    .hwrite_i (hwrite_i),
    .haddr_i  (haddr_i),
    .hwdata_i (hwdata_i),
    .req_o    (req)
  );

  sdc_regs i_regs (
    .HCLK            (HCLK),
    .reset           (reset),
    .req_i           (req),
    .clock_posedge_i (clock_posedge),
    .insert_int_i    (insert_int),
    .view_o          (view),
    .clock_div_o     (clock_div),
    .sdio_reset_o    (sdio_reset_o),
    .interrupt_o     (interrupt_o)
  );

  sdc_read_mux i_read_mux (
    .HCLK     (HCLK),
    .reset    (reset),
    .req_i    (req),
    .view_i   (view),
    .hrdata_o (hrdata_o)
  );

  //////////////////////////////
  // Card side
  //////////////////////////////
  sdc_clock_gen i_clock_gen (
    .HCLK            (HCLK),
    .reset           (reset),
    .clock_div_i     (clock_div),
    .sdio_reset_i    (sdio_reset_o),
    .clock_posedge_o (clock_posedge),
    .sdio_clk_o      (sdio_clk_o)
  );

  // Smaller width shortens the debounce in simulation
  sdc_card_detect #(
    .DEBOUNCE_W (CD_DEBOUNCE_W)
  ) i_card_detect (
    .HCLK         (HCLK),
    .sdio_cd_i    (sdio_cd_i),
    .insert_int_o (insert_int)
  );

endmodule

// File: verif/sdc_tb.sv
// Testbench for sdc_top; debounce width 6, so a card counts as present after 32 cycles
`timescale 1ns/1ps

module sdc_tb;

  //////////////////////////////
  // Run length
  //////////////////////////////
  localparam int    CLK_PERIOD    = 100;
  localparam int    RESET_CYC     = 40;
  localparam int    RANDOM_CYC    = 160;
  localparam int    CLOCK_CYC     = 320;
  localparam int    CMD_CYC       = 900;
  localparam int    DETECT_CYC    = 100;
  localparam int    MARGIN_CYC    = 500;
  localparam int    WATCHDOG_CYC  = RESET_CYC + RANDOM_CYC + CLOCK_CYC + CMD_CYC + DETECT_CYC
                                  + MARGIN_CYC;
  localparam logic [15:0] LFSR_SEED = 16'd54142;

  // Every kept register for the reset value pass
  localparam logic [7:0] ALL_OFS [13] = '{
    sdc_pkg::OFS_ARGUMENT, sdc_pkg::OFS_COMMAND, sdc_pkg::OFS_CONTROLLER,
    sdc_pkg::OFS_BLKSIZE, sdc_pkg::OFS_VOLTAGE, sdc_pkg::OFS_CAPA, sdc_pkg::OFS_CLOCK_D,
    sdc_pkg::OFS_RESET, sdc_pkg::OFS_CMD_TIMEOUT, sdc_pkg::OFS_DATA_TIMEOUT,
    sdc_pkg::OFS_BLKCNT, sdc_pkg::OFS_CARD_DETECT, sdc_pkg::OFS_DMA_ADDR
  };
  // Random write targets including read-only and unmapped offsets
  localparam logic [7:0] RANDOM_OFS [14] = '{
    sdc_pkg::OFS_ARGUMENT, sdc_pkg::OFS_COMMAND, sdc_pkg::OFS_CONTROLLER,
    sdc_pkg::OFS_BLKSIZE, sdc_pkg::OFS_VOLTAGE, sdc_pkg::OFS_CAPA, sdc_pkg::OFS_CLOCK_D,
    sdc_pkg::OFS_CMD_TIMEOUT, sdc_pkg::OFS_DATA_TIMEOUT, sdc_pkg::OFS_BLKCNT,
    sdc_pkg::OFS_CARD_DETECT, sdc_pkg::OFS_DMA_ADDR, 8'h08, 8'h7C
  };

  logic        HCLK;
  logic        reset;
  logic        hsel;
  logic        hready;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [7:0]  haddr;
  logic [31:0] hwdata;
  logic [31:0] hrdata;
  logic        hreadyout;
  logic        hresp;
  logic        sdio_cd;
  logic        sdio_clk;
  logic        sdio_reset;
  logic        interrupt;

  // Expected state
  logic [31:0] model [256];
  logic [31:0] rst_exp;
  logic        cd_present;
  logic        irq_exp;
  logic [15:0] lfsr;
  string       cur_test;

  // Check enables and their reference values
  logic        rd_phase;
  logic [31:0] rd_exp;
  string       rd_name;
  logic        clk_chk_on;
  logic        rst_chk_on;
  logic        irq_chk_on;
  int          phase_exp;
  logic        clk_q;
  int          run_len;

  sdc_top #(
    .CD_DEBOUNCE_W (6)
  ) i_dut (
    .HCLK         (HCLK),
    .reset        (reset),
    .hsel_i       (hsel),
    .hready_i     (hready),
    .htrans_i     (htrans),
    .hwrite_i     (hwrite),
    .haddr_i      (haddr),
    .hwdata_i     (hwdata),
    .hrdata_o     (hrdata),
    .hreadyout_o  (hreadyout),
    .hresp_o      (hresp),
    .sdio_cd_i    (sdio_cd),
    .sdio_clk_o   (sdio_clk),
    .sdio_reset_o (sdio_reset),
    .interrupt_o  (interrupt)
  );

  initial begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Watchdog: tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERROR %s: expected 0x%08h, actual 0x%08h", test, exp, act);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Stored width of each writable field and zero where writes are ignored
  function automatic logic [31:0] field_mask(input logic [7:0] ofs);
    case (ofs)
      sdc_pkg::OFS_ARGUMENT:     return 32'hFFFF_FFFF;
      sdc_pkg::OFS_COMMAND:      return (32'd1 << sdc_pkg::CMD_REG_W) - 1;
      sdc_pkg::OFS_CONTROLLER:   return (32'd1 << sdc_pkg::CTRL_W) - 1;
      sdc_pkg::OFS_BLKSIZE:      return (32'd1 << sdc_pkg::BLKSIZE_W) - 1;
      sdc_pkg::OFS_CLOCK_D:      return (32'd1 << sdc_pkg::CLKDIV_W) - 1;
      sdc_pkg::OFS_RESET:        return 32'h1;
      sdc_pkg::OFS_CMD_TIMEOUT:  return (32'd1 << sdc_pkg::CMD_TIMEOUT_W) - 1;
      sdc_pkg::OFS_DATA_TIMEOUT: return (32'd1 << sdc_pkg::DATA_TIMEOUT_W) - 1;
      sdc_pkg::OFS_BLKCNT:       return (32'd1 << sdc_pkg::BLKCNT_W) - 1;
      // Only the two enables
      sdc_pkg::OFS_CARD_DETECT:  return 32'h5;
      sdc_pkg::OFS_DMA_ADDR:     return 32'hFFFF_FFFF;
      default:                   return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] expect_word(input logic [7:0] ofs);
    logic [31:0] word;
    logic [31:0] cd;
    word = model[ofs];
    cd   = model[sdc_pkg::OFS_CARD_DETECT];
    if (ofs == sdc_pkg::OFS_VOLTAGE) begin
      word = 32'd3300;
    end else if (ofs == sdc_pkg::OFS_CAPA) begin
      word = 32'h0000_2003;
    end else if (ofs == sdc_pkg::OFS_RESET) begin
      word = rst_exp;
    end else if (ofs == sdc_pkg::OFS_CARD_DETECT) begin
      // remove_int, remove_ie, insert_int, insert_ie
      word = {28'd0, !cd_present, cd[2], cd_present, cd[0]};
    end
    return word;
  endfunction

  function automatic logic irq_model();
    logic [31:0] cd;
    cd = model[sdc_pkg::OFS_CARD_DETECT];
    return (cd_present & cd[0]) | (!cd_present & cd[2]);
  endfunction

  // All bus tasks start and end 10 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge HCLK);
    #10;
  endtask

  task automatic write_reg(input logic [7:0] ofs, input logic [31:0] data);
    logic save_irq;
    save_irq   = irq_chk_on;
    // Interrupt moves at the commit edge ahead of the model
    irq_chk_on = 1'b0;
    hsel       = 1'b1;
    htrans     = 2'b10;
    hwrite     = 1'b1;
    haddr      = ofs;
    wait_cycles(1);
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = data;
    wait_cycles(1);
    // Idle cycle after the commit
    hwdata = '0;
    wait_cycles(1);
    model[ofs] = data & field_mask(ofs);
    irq_exp    = irq_model();
    irq_chk_on = save_irq;
  endtask

  task automatic read_check(input logic [7:0] ofs);
    hsel   = 1'b1;
    htrans = 2'b10;
    hwrite = 1'b0;
    haddr  = ofs;
    rd_exp = expect_word(ofs);
    wait_cycles(1);
    // Data phase is checked at its closing edge
    hsel     = 1'b0;
    htrans   = 2'b00;
    rd_name  = $sformatf("%s offset 0x%02h", cur_test, ofs);
    rd_phase = 1'b1;
    wait_cycles(1);
    rd_phase = 1'b0;
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Length of the current sdio_clk level in cycles
  always @(posedge HCLK) begin
    if (reset) begin
      clk_q   <= 1'b0;
      run_len <= 0;
    end else begin
      clk_q   <= sdio_clk;
      run_len <= (sdio_clk != clk_q) ? 1 : run_len + 1;
    end
  end

  a_read_data : assert property (@(posedge HCLK) disable iff (reset)
    rd_phase |-> hrdata == rd_exp)
    else report_mismatch(rd_name, rd_exp, $sampled(hrdata));

  a_idle_zero : assert property (@(posedge HCLK) disable iff (reset)
    !rd_phase |-> hrdata == '0)
    else report_mismatch($sformatf("%s bus idle", cur_test), 32'h0, $sampled(hrdata));

  // Zero wait states and OKAY on every cycle
  a_bus_response : assert property (@(posedge HCLK) disable iff (reset)
    hreadyout && !hresp)
    else report_mismatch($sformatf("%s bus response", cur_test), 32'h1,
                         {30'd0, $sampled(hresp), $sampled(hreadyout)});

  a_reset_outputs : assert property (@(posedge HCLK)
    $fell(reset) |-> {sdio_clk, sdio_reset, interrupt} == 3'b000)
    else report_mismatch($sformatf("%s reset outputs", cur_test), 32'h0,
                         {29'd0, $sampled(sdio_clk), $sampled(sdio_reset), $sampled(interrupt)});

  a_clk_phase : assert property (@(posedge HCLK) disable iff (reset)
    (clk_chk_on && sdio_clk != clk_q) |-> run_len == phase_exp)
    else report_mismatch($sformatf("%s clock phase length", cur_test), phase_exp,
                         $sampled(run_len));

  // A stuck clock shows up as a phase that runs too long
  a_clk_running : assert property (@(posedge HCLK) disable iff (reset)
    (clk_chk_on && sdio_clk == clk_q) |-> run_len < phase_exp)
    else report_mismatch($sformatf("%s clock phase overrun", cur_test), phase_exp,
                         $sampled(run_len) + 1);

  a_clk_parked : assert property (@(posedge HCLK) disable iff (reset)
    rst_chk_on |-> (sdio_reset && sdio_clk))
    else report_mismatch($sformatf("%s card reset level", cur_test), 32'h3,
                         {30'd0, $sampled(sdio_reset), $sampled(sdio_clk)});

  a_irq : assert property (@(posedge HCLK) disable iff (reset)
    irq_chk_on |-> interrupt == irq_exp)
    else report_mismatch($sformatf("%s interrupt", cur_test), irq_exp, $sampled(interrupt));

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    logic [31:0] data;
    reset  = 1'b1;
    hsel   = 1'b0;
    hready = 1'b1;
    htrans = 2'b00;
    hwrite = 1'b0;
    haddr  = '0;
    hwdata = '0;
    sdio_cd = 1'b0;
    rd_phase = 1'b0;
    rd_exp   = '0;
    rd_name  = "";
    cur_test = "reset";
    clk_chk_on = 1'b0;
    rst_chk_on = 1'b0;
    irq_chk_on = 1'b0;
    phase_exp  = 1;
    lfsr       = LFSR_SEED;
    rst_exp    = '0;
    cd_present = 1'b0;
    irq_exp    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      model[i] = '0;
    end
    model[sdc_pkg::OFS_BLKSIZE] = 32'd511;
    model[sdc_pkg::OFS_CLOCK_D] = 32'd124;
    repeat (5) @(posedge HCLK);
    #10;
    reset = 1'b0;

    cur_test = "reset_values";
    foreach (ALL_OFS[i]) read_check(ALL_OFS[i]);

    cur_test = "write_mask";
    for (int round = 0; round < 2; round++) begin
      foreach (RANDOM_OFS[i]) begin
        random_bits(32, data);
        write_reg(RANDOM_OFS[i], data);
        read_check(RANDOM_OFS[i]);
      end
    end

    // Divider first so that the card reset clears within a short SD period
    cur_test  = "clock_divider";
    write_reg(sdc_pkg::OFS_CLOCK_D, 32'd3);
    write_reg(sdc_pkg::OFS_CONTROLLER, 32'd0);
    phase_exp = 4;
    wait_cycles(40);
    clk_chk_on = 1'b1;
    wait_cycles(80);
    clk_chk_on = 1'b0;
    write_reg(sdc_pkg::OFS_CONTROLLER, 32'd2);
    wait_cycles(20);
    rst_chk_on = 1'b1;
    wait_cycles(40);
    rst_chk_on = 1'b0;
    write_reg(sdc_pkg::OFS_CONTROLLER, 32'd0);
    wait_cycles(20);
    clk_chk_on = 1'b1;
    wait_cycles(80);
    clk_chk_on = 1'b0;

    // Start right after an SD clock rise and far from the next one
    cur_test = "cmd_start";
    write_reg(sdc_pkg::OFS_CLOCK_D, 32'd124);
    @(posedge sdio_clk);
    wait_cycles(1);
    random_bits(32, data);
    write_reg(sdc_pkg::OFS_ARGUMENT, data);
    rst_exp = 32'h8;
    read_check(sdc_pkg::OFS_RESET);
    wait_cycles(300);
    rst_exp = 32'h0;
    read_check(sdc_pkg::OFS_RESET);
    write_reg(sdc_pkg::OFS_RESET, 32'h1);
    wait_cycles(300);
    rst_exp = 32'h1;
    read_check(sdc_pkg::OFS_RESET);

    cur_test = "card_detect";
    sdio_cd  = 1'b1;
    wait_cycles(40);
    cd_present = 1'b1;
    write_reg(sdc_pkg::OFS_CARD_DETECT, 32'h1);
    read_check(sdc_pkg::OFS_CARD_DETECT);
    irq_chk_on = 1'b1;
    wait_cycles(5);
    irq_chk_on = 1'b0;
    sdio_cd    = 1'b0;
    wait_cycles(5);
    cd_present = 1'b0;
    irq_exp    = irq_model();
    read_check(sdc_pkg::OFS_CARD_DETECT);
    irq_chk_on = 1'b1;
    wait_cycles(3);
    write_reg(sdc_pkg::OFS_CARD_DETECT, 32'h4);
    read_check(sdc_pkg::OFS_CARD_DETECT);
    wait_cycles(3);
    write_reg(sdc_pkg::OFS_CARD_DETECT, 32'h0);
    read_check(sdc_pkg::OFS_CARD_DETECT);
    wait_cycles(3);
    irq_chk_on = 1'b0;

    $display("TEST OK");
    $finish;
  end

endmodule

// File: list.f
hdl/sdc_pkg.sv
hdl/sdc_ahb_slave.sv
hdl/sdc_clock_gen.sv
hdl/sdc_card_detect.sv
hdl/sdc_regs.sv
hdl/sdc_read_mux.sv
hdl/sdc_top.sv
verif/sdc_tb.sv
